//--- filelist.f
+incdir+hw
hw/vdma_pkg.sv
hw/vdma_write_channel.sv
hw/vdma_read_channel.sv
hw/vdma_port.sv
hw/burst_interconnect.sv
hw/vdma_top.sv
tests/tb_mem_model.sv
tests/tb_vdma_top.sv

//--- hw/burst_interconnect.sv
`timescale 1ns/1ps

module burst_interconnect (
    input  logic                 axi_aclk,
    input  logic                 arst_n,
    input  vdma_pkg::mem_cmd_t   port_cmd [2],
    input  vdma_pkg::mem_wbeat_t port_wbeat [2],
    output logic [1:0]           port_cmd_ready,
    output logic [1:0]           port_wready,
    output vdma_pkg::mem_rbeat_t port_rbeat [2],
    output vdma_pkg::mem_cmd_t   mem_cmd,
    input  logic                 mem_cmd_ready,
    output vdma_pkg::mem_wbeat_t mem_wbeat,
    input  logic                 mem_wready,
    input  vdma_pkg::mem_rbeat_t mem_rbeat
);
    import vdma_pkg::*;

    arb_state_t state_q;
    logic       gnt_q;
    logic       rr_q;
    logic       cmd_sent_q;
    logic       pick;
    logic       burst_end;

    // Round robin, favoured port first
    assign pick = port_cmd[rr_q].valid ? rr_q : !rr_q;

    // Write ends on accepted last beat, read on delivered last beat
    assign burst_end = (state_q == ARB_WRITE && mem_wbeat.valid && mem_wready && mem_wbeat.last)
                    || (state_q == ARB_READ && mem_rbeat.valid && mem_rbeat.last);

    always_ff @(posedge axi_aclk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= ARB_IDLE;
            gnt_q      <= 1'b0;
            rr_q       <= 1'b0;
            cmd_sent_q <= 1'b0;
        end else begin
            if (state_q == ARB_IDLE) begin
                // Grant one cycle after the command shows up
                if (port_cmd[0].valid || port_cmd[1].valid) begin
                    gnt_q      <= pick;
                    cmd_sent_q <= 1'b0;
                    state_q    <= port_cmd[pick].write ? ARB_WRITE : ARB_READ;
                end
            end else begin
                if (mem_cmd.valid && mem_cmd_ready) begin
                    cmd_sent_q <= 1'b1;
                end
                // Hand priority to the other port
                if (burst_end) begin
                    state_q <= ARB_IDLE;
                    rr_q    <= !gnt_q;
                end
            end
        end
    end

    always_comb begin
        mem_cmd         = port_cmd[gnt_q];
        mem_cmd.valid   = port_cmd[gnt_q].valid && (state_q != ARB_IDLE) && !cmd_sent_q;
        // Beats only after the command went out
        mem_wbeat       = port_wbeat[gnt_q];
        mem_wbeat.valid = port_wbeat[gnt_q].valid && (state_q == ARB_WRITE) && cmd_sent_q;
        for (int i = 0; i < 2; i++) begin
            port_cmd_ready[i]   = mem_cmd_ready && mem_cmd.valid && (gnt_q == 1'(i));
            port_wready[i]      = mem_wready && mem_wbeat.valid && (gnt_q == 1'(i));
            // Data broadcast, valid only to the granted reader
            port_rbeat[i]       = mem_rbeat;
            port_rbeat[i].valid = mem_rbeat.valid && (state_q == ARB_READ) && (gnt_q == 1'(i));
        end
    end

    // Granted port still shows the burst kind picked at grant time
    assert property (@(posedge axi_aclk) disable iff (!arst_n)
        mem_cmd.valid |-> (mem_cmd.write == (state_q == ARB_WRITE)))
        else $error("granted command changed kind");

    // Read data only for the one read burst in flight
    assert property (@(posedge axi_aclk) disable iff (!arst_n)
        mem_rbeat.valid |-> (state_q == ARB_READ) && cmd_sent_q)
        else $error("read beat outside a granted read burst");

endmodule

//--- hw/vdma_params.svh
`ifndef VDMA_PARAMS_SVH
`define VDMA_PARAMS_SVH

// Pixel and memory word widths
`define VDMA_PIX_W          32
`define VDMA_WORD_W         256
`define VDMA_PIX_PER_WORD   8

// Word address, not byte address
`define VDMA_ADDR_W         29

// Every burst on the bus has this many beats
`define VDMA_BURST_LEN      8

// One frame is 256 pixels, so 4 bursts
`define VDMA_FRAME_WORDS    32

// Words in each channel buffer
`define VDMA_FIFO_DEPTH     16

// Word base address of each port
`define VDMA_PORT_BASE0     0
`define VDMA_PORT_BASE1     1024

`endif

//--- hw/vdma_pkg.sv
`include "vdma_params.svh"

package vdma_pkg;

    // Stream and memory data
    typedef logic [`VDMA_PIX_W-1:0]  pixel_t;
    // Pixel k sits in lane k, lane 0 at the LSBs
    typedef logic [`VDMA_WORD_W-1:0] word_t;
    typedef logic [`VDMA_ADDR_W-1:0] addr_t;

    // Burst command, length is always VDMA_BURST_LEN
    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
    } mem_cmd_t;

    // Write beat, handshaked with wready
    typedef struct packed {
        logic  valid;
        word_t data;
        logic  last;
    } mem_wbeat_t;

    // Read beat, no ready
    typedef struct packed {
        logic  valid;
        word_t data;
        logic  last;
    } mem_rbeat_t;

    // Write channel FSM
    typedef enum logic [1:0] {
        WR_FILL,
        WR_CMD,
        WR_DATA,
        WR_DONE
    } wr_state_t;

    // Interconnect FSM
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WRITE,
        ARB_READ
    } arb_state_t;

endpackage

//--- hw/vdma_port.sv
`timescale 1ns/1ps

module vdma_port #(
    parameter vdma_pkg::addr_t BASE_ADDR = '0
) (
    input  logic                 axi_aclk,
    input  logic                 arst_n,
    input  logic                 pix_in_valid,
    input  vdma_pkg::pixel_t     pix_in,
    input  logic                 rd_start,
    input  logic                 cmd_ready,
    input  logic                 wready,
    input  vdma_pkg::mem_rbeat_t rbeat,
    output vdma_pkg::mem_cmd_t   cmd,
    output vdma_pkg::mem_wbeat_t wbeat,
    output logic                 pix_out_valid,
    output vdma_pkg::pixel_t     pix_out,
    output logic                 wr_done,
    output logic                 rd_done
);
    import vdma_pkg::*;

    mem_cmd_t wr_cmd;
    mem_cmd_t rd_cmd;
    logic     wr_cmd_ready;
    logic     rd_cmd_ready;
    logic     sel_rd;
    logic     lock_q;
    logic     lock_rd_q;

    vdma_write_channel #(
        .BASE_ADDR    (BASE_ADDR)
    ) u_wr (
        .axi_aclk     (axi_aclk),
        .arst_n       (arst_n),
        .pix_in_valid (pix_in_valid),
        .pix_in       (pix_in),
        .cmd_ready    (wr_cmd_ready),
        .wready       (wready),
        .cmd          (wr_cmd),
        .wbeat        (wbeat),
        .wr_done      (wr_done)
    );

    vdma_read_channel #(
        .BASE_ADDR     (BASE_ADDR)
    ) u_rd (
        .axi_aclk      (axi_aclk),
        .arst_n        (arst_n),
        .rd_start      (rd_start),
        .cmd_ready     (rd_cmd_ready),
        .rbeat         (rbeat),
        .cmd           (rd_cmd),
        .pix_out_valid (pix_out_valid),
        .pix_out       (pix_out),
        .rd_done       (rd_done)
    );

    // Write wins, unless a read is already waiting on the bus
    assign sel_rd       = lock_q ? lock_rd_q : !wr_cmd.valid;
    assign cmd          = sel_rd ? rd_cmd : wr_cmd;
    assign wr_cmd_ready = cmd_ready && !sel_rd;
    assign rd_cmd_ready = cmd_ready && sel_rd;

    always_ff @(posedge axi_aclk or negedge arst_n) begin
        if (!arst_n) begin
            lock_q    <= 1'b0;
            lock_rd_q <= 1'b0;
        end else begin
            // Pending command keeps the selection
            lock_q    <= cmd.valid && !cmd_ready;
            lock_rd_q <= sel_rd;
        end
    end

endmodule

//--- hw/vdma_read_channel.sv
`timescale 1ns/1ps
`include "vdma_params.svh"

module vdma_read_channel #(
    parameter vdma_pkg::addr_t BASE_ADDR = '0
) (
    input  logic                 axi_aclk,
    input  logic                 arst_n,
    input  logic                 rd_start,
    input  logic                 cmd_ready,
    input  vdma_pkg::mem_rbeat_t rbeat,
    output vdma_pkg::mem_cmd_t   cmd,
    output logic                 pix_out_valid,
    output vdma_pkg::pixel_t     pix_out,
    output logic                 rd_done
);
    import vdma_pkg::*;

    localparam int FRAME_PIX = `VDMA_FRAME_WORDS * `VDMA_PIX_PER_WORD;
    localparam int BURSTS    = `VDMA_FRAME_WORDS / `VDMA_BURST_LEN;
    localparam int PTR_W     = $clog2(`VDMA_FIFO_DEPTH);
    localparam int RES_W     = PTR_W + 1;
    localparam int LANE_W    = $clog2(`VDMA_PIX_PER_WORD);
    localparam logic [RES_W-1:0] BURST_WORDS = `VDMA_BURST_LEN;

    logic                        started_q;
    logic [$clog2(BURSTS+1)-1:0] burst_cnt_q;
    logic [RES_W-1:0]            reserved_q;
    word_t                       fifo_mem [`VDMA_FIFO_DEPTH];
    logic [PTR_W:0]              wr_ptr_q;
    logic [PTR_W:0]              rd_ptr_q;
    logic [PTR_W:0]              fifo_cnt;
    word_t                       unpk_q;
    logic                        unpk_full_q;
    logic [LANE_W-1:0]           lane_q;
    logic [$clog2(FRAME_PIX):0]  out_cnt_q;
    logic                        rd_done_q;
    logic                        cmd_fire;
    logic                        pop;

    assign fifo_cnt = wr_ptr_q - rd_ptr_q;
    assign cmd_fire = cmd.valid && cmd_ready;
    // Refill the unpacker as its last lane goes out
    assign pop      = (fifo_cnt != 0) && (!unpk_full_q || (lane_q == '1));

    // Only ask when the whole burst fits, counting words in flight
    always_comb begin
        cmd.valid = started_q && (burst_cnt_q != BURSTS)
                    && (reserved_q <= `VDMA_FIFO_DEPTH - `VDMA_BURST_LEN);
        cmd.write = 1'b0;
        cmd.addr  = BASE_ADDR + addr_t'(burst_cnt_q * `VDMA_BURST_LEN);
    end

    assign pix_out_valid = unpk_full_q;
    assign pix_out       = unpk_q[`VDMA_PIX_W-1:0];
    assign rd_done       = rd_done_q;

    always_ff @(posedge axi_aclk) begin
        if (rbeat.valid) begin
            fifo_mem[wr_ptr_q[PTR_W-1:0]] <= rbeat.data;
        end
        // Lane 0 first, shift down each cycle
        if (pop) begin
            unpk_q <= fifo_mem[rd_ptr_q[PTR_W-1:0]];
        end else if (unpk_full_q) begin
            unpk_q <= unpk_q >> `VDMA_PIX_W;
        end
    end

    always_ff @(posedge axi_aclk or negedge arst_n) begin
        if (!arst_n) begin
            started_q   <= 1'b0;
            burst_cnt_q <= '0;
            reserved_q  <= '0;
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
        end else begin
            if (rd_start) begin
                started_q <= 1'b1;
            end
            if (cmd_fire) begin
                burst_cnt_q <= burst_cnt_q + 1'b1;
            end
            // Words buffered plus words still owed by memory
            reserved_q <= reserved_q + (cmd_fire ? BURST_WORDS : '0) - RES_W'(pop);
            if (rbeat.valid) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Unpacker and frame end
    always_ff @(posedge axi_aclk or negedge arst_n) begin
        if (!arst_n) begin
            unpk_full_q <= 1'b0;
            lane_q      <= '0;
            out_cnt_q   <= '0;
            rd_done_q   <= 1'b0;
        end else begin
            if (pop) begin
                unpk_full_q <= 1'b1;
                lane_q      <= '0;
            end else if (unpk_full_q) begin
                lane_q <= lane_q + 1'b1;
                if (lane_q == '1) begin
                    unpk_full_q <= 1'b0;
                end
            end
            if (unpk_full_q) begin
                out_cnt_q <= out_cnt_q + 1'b1;
                if (out_cnt_q == FRAME_PIX - 1) begin
                    rd_done_q <= 1'b1;
                end
            end
        end
    end

    // Reservation and interconnect routing keep this from firing
    assert property (@(posedge axi_aclk) disable iff (!arst_n)
        rbeat.valid |-> (fifo_cnt < `VDMA_FIFO_DEPTH) || pop)
        else $error("read FIFO overflow");

endmodule

//--- hw/vdma_top.sv
`timescale 1ns/1ps
`include "vdma_params.svh"

module vdma_top (
    input  logic                 axi_aclk,
    input  logic                 arst_n,
    input  logic [1:0]           pix_in_valid,
    input  vdma_pkg::pixel_t     pix_in [2],
    input  logic [1:0]           rd_start,
    output logic [1:0]           pix_out_valid,
    output vdma_pkg::pixel_t     pix_out [2],
    output logic [1:0]           wr_done,
    output logic [1:0]           rd_done,
    output vdma_pkg::mem_cmd_t   mem_cmd,
    input  logic                 mem_cmd_ready,
    output vdma_pkg::mem_wbeat_t mem_wbeat,
    input  logic                 mem_wready,
    input  vdma_pkg::mem_rbeat_t mem_rbeat
);
    import vdma_pkg::*;

    mem_cmd_t   port_cmd [2];
    mem_wbeat_t port_wbeat [2];
    mem_rbeat_t port_rbeat [2];
    logic [1:0] port_cmd_ready;
    logic [1:0] port_wready;

    // Port 0 and port 1 differ only in base address
    for (genvar i = 0; i < 2; i++) begin : g_port
        vdma_port #(
            .BASE_ADDR     (i == 0 ? addr_t'(`VDMA_PORT_BASE0) : addr_t'(`VDMA_PORT_BASE1))
        ) u_port (
            .axi_aclk      (axi_aclk),
            .arst_n        (arst_n),
            .pix_in_valid  (pix_in_valid[i]),
            .pix_in        (pix_in[i]),
            .rd_start      (rd_start[i]),
            .cmd_ready     (port_cmd_ready[i]),
            .wready        (port_wready[i]),
            .rbeat         (port_rbeat[i]),
            .cmd           (port_cmd[i]),
            .wbeat         (port_wbeat[i]),
            .pix_out_valid (pix_out_valid[i]),
            .pix_out       (pix_out[i]),
            .wr_done       (wr_done[i]),
            .rd_done       (rd_done[i])
        );
    end

    // Both ports share the one memory bus
    burst_interconnect u_ic (
        .axi_aclk       (axi_aclk),
        .arst_n         (arst_n),
        .port_cmd       (port_cmd),
        .port_wbeat     (port_wbeat),
        .port_cmd_ready (port_cmd_ready),
        .port_wready    (port_wready),
        .port_rbeat     (port_rbeat),
        .mem_cmd        (mem_cmd),
        .mem_cmd_ready  (mem_cmd_ready),
        .mem_wbeat      (mem_wbeat),
        .mem_wready     (mem_wready),
        .mem_rbeat      (mem_rbeat)
    );

endmodule

//--- hw/vdma_write_channel.sv
`timescale 1ns/1ps
`include "vdma_params.svh"

module vdma_write_channel #(
    parameter vdma_pkg::addr_t BASE_ADDR = '0
) (
    input  logic                 axi_aclk,
    input  logic                 arst_n,
    input  logic                 pix_in_valid,
    input  vdma_pkg::pixel_t     pix_in,
    input  logic                 cmd_ready,
    input  logic                 wready,
    output vdma_pkg::mem_cmd_t   cmd,
    output vdma_pkg::mem_wbeat_t wbeat,
    output logic                 wr_done
);
    import vdma_pkg::*;

    localparam int FRAME_PIX = `VDMA_FRAME_WORDS * `VDMA_PIX_PER_WORD;
    localparam int BURSTS    = `VDMA_FRAME_WORDS / `VDMA_BURST_LEN;
    localparam int PTR_W     = $clog2(`VDMA_FIFO_DEPTH);
    localparam int LANE_W    = $clog2(`VDMA_PIX_PER_WORD);

    wr_state_t                          state_q;
    logic [$clog2(FRAME_PIX):0]         pix_cnt_q;
    logic                               push_q;
    word_t                              pack_q;
    word_t                              fifo_mem [`VDMA_FIFO_DEPTH];
    logic [PTR_W:0]                     wr_ptr_q;
    logic [PTR_W:0]                     rd_ptr_q;
    logic [PTR_W:0]                     fifo_cnt;
    logic [$clog2(`VDMA_BURST_LEN)-1:0] beat_cnt_q;
    logic [$clog2(BURSTS+1)-1:0]        burst_cnt_q;
    logic                               pix_take;
    logic                               pop;
    logic                               last_beat;

    // Pixels past the end of the frame are dropped
    assign pix_take  = pix_in_valid && (pix_cnt_q != FRAME_PIX);
    assign fifo_cnt  = wr_ptr_q - rd_ptr_q;
    assign last_beat = (beat_cnt_q == `VDMA_BURST_LEN - 1);
    assign pop       = wbeat.valid && wready;
    assign wr_done   = (state_q == WR_DONE);

    // Shift in from the top, first pixel ends in lane 0
    always_ff @(posedge axi_aclk) begin
        if (pix_take) begin
            pack_q <= {pix_in, pack_q[`VDMA_WORD_W-1:`VDMA_PIX_W]};
        end
        // Full word lands in FIFO one cycle after 8th strobe
        if (push_q) begin
            fifo_mem[wr_ptr_q[PTR_W-1:0]] <= pack_q;
        end
    end

    always_ff @(posedge axi_aclk or negedge arst_n) begin
        if (!arst_n) begin
            pix_cnt_q <= '0;
            push_q    <= 1'b0;
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
        end else begin
            push_q <= pix_take && (pix_cnt_q[LANE_W-1:0] == '1);
            if (pix_take) begin
                pix_cnt_q <= pix_cnt_q + 1'b1;
            end
            if (push_q) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Burst sequencer
    always_ff @(posedge axi_aclk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= WR_FILL;
            beat_cnt_q  <= '0;
            burst_cnt_q <= '0;
        end else begin
            case (state_q)
                WR_FILL: begin
                    // Whole burst buffered before asking for the bus
                    if (fifo_cnt >= `VDMA_BURST_LEN) begin
                        state_q <= WR_CMD;
                    end
                end
                WR_CMD: begin
                    if (cmd_ready) begin
                        state_q <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (pop) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (last_beat) begin
                            burst_cnt_q <= burst_cnt_q + 1'b1;
                            state_q     <= (burst_cnt_q == BURSTS - 1) ? WR_DONE : WR_FILL;
                        end
                    end
                end
                default: begin
                    // Frame stored, stay here
                    state_q <= WR_DONE;
                end
            endcase
        end
    end

    always_comb begin
        cmd.valid   = (state_q == WR_CMD);
        cmd.write   = 1'b1;
        cmd.addr    = BASE_ADDR + addr_t'(burst_cnt_q * `VDMA_BURST_LEN);
        wbeat.valid = (state_q == WR_DATA);
        wbeat.data  = fifo_mem[rd_ptr_q[PTR_W-1:0]];
        wbeat.last  = last_beat;
    end

    // Bus must keep up with the pixel rate
    assert property (@(posedge axi_aclk) disable iff (!arst_n)
        push_q |-> (fifo_cnt < `VDMA_FIFO_DEPTH) || pop)
        else $error("write FIFO overflow");

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the VDMA testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_vdma_top -Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASSED" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi

//--- tests/tb_mem_model.sv
`timescale 1ns/1ps
`include "vdma_params.svh"

module tb_mem_model (
    input  logic                 axi_aclk,
    input  logic                 arst_n,
    input  logic                 stall_en,
    input  vdma_pkg::mem_cmd_t   mem_cmd,
    output logic                 mem_cmd_ready,
    input  vdma_pkg::mem_wbeat_t mem_wbeat,
    output logic                 mem_wready,
    output vdma_pkg::mem_rbeat_t mem_rbeat
);
    import vdma_pkg::*;

    localparam int MEM_WORDS = 2048;
    localparam int LOG_DEPTH = 16;

    word_t      mem [MEM_WORDS];
    addr_t      wr_log [LOG_DEPTH];
    int         wr_log_cnt;
    int         proto_err;
    integer     seed;
    logic [31:0] rnd;
    logic       rst_s;
    logic       cmd_fire;
    logic       wbeat_fire;
    logic       rbeat_sent;
    mem_cmd_t   cmd_s;
    mem_wbeat_t wbeat_s;
    logic       busy;
    logic       is_write;
    addr_t      cur_addr;
    int         beat_cnt;

    initial begin
        seed          = 32'h2bf84b68;
        mem_cmd_ready = 1'b0;
        mem_wready    = 1'b0;
        mem_rbeat     = '0;
        busy          = 1'b0;
        is_write      = 1'b0;
        cur_addr      = '0;
        beat_cnt      = 0;
        wr_log_cnt    = 0;
        proto_err     = 0;
        // Fill pattern from the whole word index
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {8{32'hDEAD_0000 ^ 32'(i)}};
        end
    end

    always begin
        // Handshake signals have settled by the falling edge
        @(negedge axi_aclk);
        rst_s      = !arst_n;
        cmd_s      = mem_cmd;
        wbeat_s    = mem_wbeat;
        cmd_fire   = mem_cmd.valid && mem_cmd_ready;
        wbeat_fire = mem_wbeat.valid && mem_wready;
        rbeat_sent = mem_rbeat.valid;
        @(posedge axi_aclk);
        #1;
        if (rst_s) begin
            busy       = 1'b0;
            wr_log_cnt = 0;
            proto_err  = 0;
        end else if (cmd_fire) begin
            busy     = 1'b1;
            is_write = cmd_s.write;
            cur_addr = cmd_s.addr;
            beat_cnt = 0;
            // Every accepted write command goes into the log
            if (cmd_s.write) begin
                if (wr_log_cnt < LOG_DEPTH) begin
                    wr_log[wr_log_cnt] = cmd_s.addr;
                end
                wr_log_cnt++;
            end
        end else if (wbeat_fire || rbeat_sent) begin
            if (wbeat_fire) begin
                if (wbeat_s.last != (beat_cnt == `VDMA_BURST_LEN - 1)) begin
                    $display("Memory model saw the last flag on the wrong write beat %0d",
                             beat_cnt);
                    proto_err++;
                end
                if (cur_addr >= addr_t'(MEM_WORDS)) begin
                    $display("Memory model got a write beyond its size at %h", cur_addr);
                    proto_err++;
                end else begin
                    mem[cur_addr[10:0]] = wbeat_s.data;
                end
            end
            cur_addr = cur_addr + 1'b1;
            beat_cnt++;
            if (beat_cnt == `VDMA_BURST_LEN) begin
                busy = 1'b0;
            end
        end
        // About one cycle in four stalls when enabled
        rnd             = $random(seed);
        mem_cmd_ready   = !busy && (!stall_en || rnd[1:0] != 2'b00);
        mem_wready      = busy && is_write && (!stall_en || rnd[3:2] != 2'b00);
        mem_rbeat.valid = busy && !is_write && (!stall_en || rnd[5:4] != 2'b00);
        mem_rbeat.data  = mem[cur_addr[10:0]];
        mem_rbeat.last  = (beat_cnt == `VDMA_BURST_LEN - 1);
    end

endmodule

//--- tests/tb_vdma_top.sv
`timescale 1ns/1ps
`include "vdma_params.svh"

module tb_vdma_top;
    import vdma_pkg::*;

    localparam int FRAME_PIX = `VDMA_FRAME_WORDS * `VDMA_PIX_PER_WORD;
    localparam int BURSTS    = `VDMA_FRAME_WORDS / `VDMA_BURST_LEN;
    localparam int ROWS      = 3;

    // First pixel of each port, cycles between strobes, random stalls
    typedef struct packed {
        pixel_t first0;
        pixel_t first1;
        int     gap;
        logic   stall;
    } test_row_t;

    // Pixel ranges of the two ports never overlap
    localparam test_row_t TESTS [ROWS] = '{
        '{32'h0000_0000, 32'h0001_0000, 1, 1'b0},
        '{32'hA5A5_0100, 32'h5A5A_8000, 2, 1'b1},
        '{32'hFFFF_FF80, 32'h7FFF_FFC0, 3, 1'b1}
    };

    logic       axi_aclk;
    logic       arst_n;
    logic [1:0] pix_in_valid;
    pixel_t     pix_in [2];
    logic [1:0] rd_start;
    logic [1:0] pix_out_valid;
    pixel_t     pix_out [2];
    logic [1:0] wr_done;
    logic [1:0] rd_done;
    mem_cmd_t   mem_cmd;
    logic       mem_cmd_ready;
    mem_wbeat_t mem_wbeat;
    logic       mem_wready;
    mem_rbeat_t mem_rbeat;
    logic       stall_en;
    int         err_cnt;
    int         check_cnt;
    int         cycle_cnt;
    int         cycle_limit;

    vdma_top dut0 (
        .axi_aclk      (axi_aclk),
        .arst_n        (arst_n),
        .pix_in_valid  (pix_in_valid),
        .pix_in        (pix_in),
        .rd_start      (rd_start),
        .pix_out_valid (pix_out_valid),
        .pix_out       (pix_out),
        .wr_done       (wr_done),
        .rd_done       (rd_done),
        .mem_cmd       (mem_cmd),
        .mem_cmd_ready (mem_cmd_ready),
        .mem_wbeat     (mem_wbeat),
        .mem_wready    (mem_wready),
        .mem_rbeat     (mem_rbeat)
    );

    tb_mem_model mem0 (
        .axi_aclk      (axi_aclk),
        .arst_n        (arst_n),
        .stall_en      (stall_en),
        .mem_cmd       (mem_cmd),
        .mem_cmd_ready (mem_cmd_ready),
        .mem_wbeat     (mem_wbeat),
        .mem_wready    (mem_wready),
        .mem_rbeat     (mem_rbeat)
    );

    initial axi_aclk = 1'b0;
    always #5 axi_aclk = ~axi_aclk;

    // Watchdog over the whole run
    always @(posedge axi_aclk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bits(input string name, input logic [1:0] got, input logic [1:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic addr_t port_base(input logic p);
        return p ? addr_t'(`VDMA_PORT_BASE1) : addr_t'(`VDMA_PORT_BASE0);
    endfunction

    // Word j holds pixels 8j to 8j+7, lane 0 first
    function automatic word_t pack_pixels(input pixel_t first, input int j);
        word_t w;
        for (int k = 0; k < `VDMA_PIX_PER_WORD; k++) begin
            w[k*`VDMA_PIX_W +: `VDMA_PIX_W] = first + pixel_t'(j * `VDMA_PIX_PER_WORD + k);
        end
        return w;
    endfunction

    // Model array covers 2048 words
    function automatic word_t stored_word(input addr_t a);
        return mem0.mem[a[10:0]];
    endfunction

    task automatic apply_reset(input logic stall);
        @(posedge axi_aclk);
        #1;
        arst_n       = 1'b0;
        stall_en     = stall;
        pix_in_valid = 2'b00;
        rd_start     = 2'b00;
        repeat (5) @(posedge axi_aclk);
        #1;
        arst_n = 1'b1;
        // Everything idle right after reset
        @(negedge axi_aclk);
        check_bits("{mem_cmd.valid, mem_wbeat.valid}", {mem_cmd.valid, mem_wbeat.valid}, 2'b00);
        check_bits("pix_out_valid", pix_out_valid, 2'b00);
        check_bits("wr_done", wr_done, 2'b00);
        check_bits("rd_done", rd_done, 2'b00);
    endtask

    // Both ports stream at once, strobe every gap cycles
    task automatic send_frames(input pixel_t first0, input pixel_t first1, input int gap);
        for (int i = 0; i < FRAME_PIX; i++) begin
            @(posedge axi_aclk);
            #1;
            pix_in_valid = 2'b11;
            pix_in[0]    = first0 + pixel_t'(i);
            pix_in[1]    = first1 + pixel_t'(i);
            repeat (gap - 1) begin
                @(posedge axi_aclk);
                #1;
                pix_in_valid = 2'b00;
            end
        end
        @(posedge axi_aclk);
        #1;
        pix_in_valid = 2'b00;
    endtask

    // Check stored frame, then start readback
    task automatic finish_write(input logic p, input pixel_t first);
        addr_t base;
        base = port_base(p);
        @(negedge axi_aclk);
        while (!wr_done[p]) begin
            @(negedge axi_aclk);
        end
        for (int j = 0; j < `VDMA_FRAME_WORDS; j++) begin
            check_word($sformatf("mem[%h]", base + addr_t'(j)), stored_word(base + addr_t'(j)),
                       pack_pixels(first, j));
        end
        @(posedge axi_aclk);
        #1;
        rd_start[p] = 1'b1;
    endtask

    task automatic collect_pixels(input logic p, input pixel_t first);
        int cnt;
        int extra;
        cnt   = 0;
        extra = 0;
        @(negedge axi_aclk);
        while (!rd_done[p]) begin
            if (pix_out_valid[p]) begin
                check_pixel($sformatf("pix_out[%0d]", p), pix_out[p], first + pixel_t'(cnt));
                cnt++;
            end
            @(negedge axi_aclk);
        end
        // Nothing more once the frame is delivered
        repeat (16) begin
            if (pix_out_valid[p]) begin
                extra++;
            end
            @(negedge axi_aclk);
        end
        check_cnt++;
        if (cnt != FRAME_PIX || extra != 0) begin
            err_cnt++;
            $display("Port %0d delivered %0d pixels before rd_done and %0d after it",
                     p, cnt, extra);
        end
    endtask

    // Each port writes bursts 0 to 3 in order at its own base
    task automatic check_write_log();
        int   k [2];
        logic p;
        k = '{0, 0};
        for (int i = 0; i < mem0.wr_log_cnt && i < 16; i++) begin
            p = (mem0.wr_log[i] >= addr_t'(`VDMA_PORT_BASE1));
            check_addr($sformatf("write cmd %0d addr", i), mem0.wr_log[i],
                       port_base(p) + addr_t'(`VDMA_BURST_LEN * k[p]));
            k[p]++;
        end
        check_cnt++;
        if (k[0] != BURSTS || k[1] != BURSTS || mem0.wr_log_cnt != 2 * BURSTS) begin
            err_cnt++;
            $display("Expected %0d write commands per port, saw %0d and %0d of %0d",
                     BURSTS, k[0], k[1], mem0.wr_log_cnt);
        end
    endtask

    initial begin
        int row_err;
        arst_n       = 1'b0;
        stall_en     = 1'b0;
        pix_in_valid = 2'b00;
        pix_in[0]    = '0;
        pix_in[1]    = '0;
        rd_start     = 2'b00;
        err_cnt      = 0;
        check_cnt    = 0;
        cycle_cnt    = 0;
        cycle_limit  = 0;
        for (int r = 0; r < ROWS; r++) begin
            cycle_limit += 5 + 2 * FRAME_PIX * TESTS[r].gap + 2000;
        end
        for (int r = 0; r < ROWS; r++) begin
            row_err = err_cnt;
            apply_reset(TESTS[r].stall);
            fork
                send_frames(TESTS[r].first0, TESTS[r].first1, TESTS[r].gap);
                finish_write(1'b0, TESTS[r].first0);
                finish_write(1'b1, TESTS[r].first1);
                collect_pixels(1'b0, TESTS[r].first0);
                collect_pixels(1'b1, TESTS[r].first1);
            join
            check_write_log();
            // Bus protocol faults seen by the memory model
            err_cnt += mem0.proto_err;
            $display("test %0d gap %0d stall %0d: %s, %0d errors", r, TESTS[r].gap,
                     TESTS[r].stall, (err_cnt == row_err) ? "ok" : "failed", err_cnt - row_err);
        end
        $display("%0d tests, %0d checks, %0d errors", ROWS, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
